/* rtl/photon_pkg.sv */
package photon_pkg;

    //////////////////////////////
    // Sizes and timing.
    //////////////////////////////
    localparam int BUF_DEPTH         = 1024;  // Records in the count buffer.
    localparam int BAUD_DIV          = 1157;  // 133.33 MHz / 115200 baud.
    localparam int SIM_SYNC_PERIOD   = 4000;  // Simulated sync period, in clocks.
    localparam int SIM_SYNC_HIGH     = 20;    // Simulated sync high time.
    localparam int SIM_PHOTON_PERIOD = 40;    // Simulated photon period, half high.

    //////////////////////////////
    // Vector types.
    //////////////////////////////
    typedef logic [15:0] count_t;       // Photons in one window, saturating.
    typedef logic [9:0]  buf_addr_t;    // Record address, wraps at BUF_DEPTH.
    typedef logic [7:0]  uart_byte_t;   // One UART payload byte.
    typedef logic [10:0] baud_cnt_t;    // Bit timer, holds BAUD_DIV - 1.
    typedef logic [10:0] pend_cnt_t;    // Unread records, up to BUF_DEPTH.
    typedef logic [11:0] sync_cnt_t;    // Simulated sync phase.
    typedef logic [5:0]  photon_cnt_t;  // Simulated photon phase.

    //////////////////////////////
    // Buses.
    //////////////////////////////
    // Arbiter to buffer.
    typedef struct packed {
        logic      en;      // Access this cycle.
        logic      we;      // Write when set, else read.
        buf_addr_t addr;
        count_t    wdata;
    } buf_cmd_t;

    // Counter to arbiter, one closed window.
    typedef struct packed {
        buf_addr_t addr;
        count_t    data;
    } record_wr_t;

    //////////////////////////////
    // FSM states.
    //////////////////////////////
    typedef enum logic {
        ARB_IDLE,
        ARB_ACCESS
    } arb_state_t;

    typedef enum logic [2:0] {
        REP_IDLE,
        REP_READ,
        REP_START,
        REP_BITS,
        REP_STOP,
        REP_NEXT    // Second byte or end of record.
    } rep_state_t;

endpackage

/* rtl/pulse_counter.sv */
`timescale 1ns/1ps

module pulse_counter import photon_pkg::*; (
    input  logic       clk_133MHz_210,
    input  logic       rst_n,
    input  logic       photon_pulse,   // Photon pin, asynchronous.
    input  logic       sync_50hz,      // Window sync pin, asynchronous.
    output logic       wr_req,         // Held until wr_done.
    output record_wr_t wr_record,
    input  logic       wr_done,
    output logic       overrun         // Sticky, window lost.
);

    //////////////////////////////
    // Synchronizers and edges.
    //////////////////////////////
    logic [2:0] photon_sr;  // Two sync flops plus edge register.
    logic [2:0] sync_sr;
    logic       photon_rise;
    logic       sync_rise;

    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            photon_sr <= '0;
            sync_sr   <= '0;
        end else begin
            photon_sr <= {photon_sr[1:0], photon_pulse};
            sync_sr   <= {sync_sr[1:0], sync_50hz};
        end
    end

    assign photon_rise = photon_sr[1] & ~photon_sr[2];
    assign sync_rise   = sync_sr[1] & ~sync_sr[2];  // Window close strobe.

    //////////////////////////////
    // Window count.
    //////////////////////////////
    count_t    count;
    count_t    count_inc;   // Count including this cycle's edge.
    buf_addr_t wr_addr;
    logic      pending;     // Previous record not yet taken.

    // Saturate at all ones.
    assign count_inc = (photon_rise && count != '1) ? count + 1'b1 : count;
    assign pending   = wr_req & ~wr_done;

    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            count   <= '0;
            wr_addr <= '0;
            wr_req  <= 1'b0;
            overrun <= 1'b0;
        end else begin
            if (wr_done)
                wr_req <= 1'b0;     // Record accepted.
            if (sync_rise) begin
                count <= '0;        // New window.
                if (pending) begin
                    overrun <= 1'b1;    // Drop this window.
                end else begin
                    wr_req  <= 1'b1;
                    wr_addr <= wr_addr + 1'b1;  // Wraps at BUF_DEPTH.
                end
            end else begin
                count <= count_inc;
            end
        end
    end

    // Record payload, loaded only when posted.
    always_ff @(posedge clk_133MHz_210) begin
        if (sync_rise && !pending) begin
            wr_record.addr <= wr_addr;
            wr_record.data <= count_inc;
        end
    end

    // Payload may not move under a held request.
    a_record_stable: assert property (
        @(posedge clk_133MHz_210) disable iff (!rst_n)
        wr_req && !wr_done |=> $stable(wr_record)
    );

endmodule

/* rtl/rw_arbiter.sv */
`timescale 1ns/1ps

module rw_arbiter import photon_pkg::*; (
    input  logic       clk_133MHz_210,
    input  logic       rst_n,
    // Write side.
    input  logic       wr_req,
    input  record_wr_t wr_record,
    output logic       wr_done,
    // Read side.
    input  logic       rd_req,
    input  buf_addr_t  rd_addr,
    output logic       rd_done,
    output count_t     rd_data,
    // Buffer side.
    output buf_cmd_t   buf_cmd,
    input  count_t     buf_rdata
);

    arb_state_t state;
    logic       grant_wr;   // Current access is the write.

    //////////////////////////////
    // Command, issued in the grant cycle.
    //////////////////////////////
    always_comb begin
        buf_cmd = '0;
        if (state == ARB_IDLE) begin
            if (wr_req) begin              // Writes first.
                buf_cmd.en    = 1'b1;
                buf_cmd.we    = 1'b1;
                buf_cmd.addr  = wr_record.addr;
                buf_cmd.wdata = wr_record.data;
            end else if (rd_req) begin
                buf_cmd.en   = 1'b1;
                buf_cmd.addr = rd_addr;
            end
        end
    end

    //////////////////////////////
    // Grant FSM.
    //////////////////////////////
    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ARB_IDLE;
            grant_wr <= 1'b0;
        end else begin
            case (state)
                ARB_IDLE:
                    if (wr_req || rd_req) begin
                        grant_wr <= wr_req;
                        state    <= ARB_ACCESS;
                    end
                ARB_ACCESS:
                    state <= ARB_IDLE;   // Requester drops on done.
                default:
                    state <= ARB_IDLE;
            endcase
        end
    end

    // Done one cycle after grant, read data arrives with it.
    assign wr_done = (state == ARB_ACCESS) &&  grant_wr;
    assign rd_done = (state == ARB_ACCESS) && !grant_wr;
    assign rd_data = buf_rdata;

    // Never both, and only to a side still holding its request.
    a_done_exclusive: assert property (
        @(posedge clk_133MHz_210) disable iff (!rst_n)
        !(wr_done && rd_done) && (!wr_done || wr_req) && (!rd_done || rd_req)
    );

endmodule

/* rtl/count_buffer.sv */
`timescale 1ns/1ps

module count_buffer import photon_pkg::*; (
    input  logic     clk_133MHz_210,
    input  buf_cmd_t buf_cmd,
    output count_t   buf_rdata    // Valid one cycle after a read.
);

    //////////////////////////////
    // Storage.
    //////////////////////////////
    count_t mem [BUF_DEPTH];

    always_ff @(posedge clk_133MHz_210) begin
        if (buf_cmd.en) begin
            if (buf_cmd.we)
                mem[buf_cmd.addr] <= buf_cmd.wdata;
            buf_rdata <= mem[buf_cmd.addr];     // Old data on a write.
        end
    end

endmodule

/* rtl/count_reporter.sv */
`timescale 1ns/1ps

module count_reporter import photon_pkg::*; (
    input  logic      clk_133MHz_210,
    input  logic      rst_n,
    input  logic      record_written,  // One pulse per stored record.
    output logic      rd_req,          // Held until rd_done.
    output buf_addr_t rd_addr,
    input  logic      rd_done,
    input  count_t    rd_data,
    output logic      uart_txd
);

    rep_state_t state;
    pend_cnt_t  pend_cnt;     // Records not read yet.
    count_t     rec_data;     // Record being sent.
    uart_byte_t tx_byte;      // Byte being shifted.
    logic       low_sent;     // Second byte under way.
    logic [2:0] bit_idx;      // Data bit, LSB first.
    baud_cnt_t  bit_tmr;
    logic       bit_end;
    logic       tx_level;

    //////////////////////////////
    // Pending records.
    //////////////////////////////
    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n)
            pend_cnt <= '0;
        else if (record_written && !rd_done)
            pend_cnt <= pend_cnt + 1'b1;
        else if (rd_done && !record_written)
            pend_cnt <= pend_cnt - 1'b1;
    end

    //////////////////////////////
    // Bit timer.
    //////////////////////////////
    assign bit_end = (bit_tmr == baud_cnt_t'(BAUD_DIV - 1));

    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n)
            bit_tmr <= '0;
        else if (state == REP_START || state == REP_BITS || state == REP_STOP)
            bit_tmr <= bit_end ? '0 : bit_tmr + 1'b1;
        else
            bit_tmr <= '0;      // Restart for each byte.
    end

    //////////////////////////////
    // Reporter FSM.
    //////////////////////////////
    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            state    <= REP_IDLE;
            rd_req   <= 1'b0;
            rd_addr  <= '0;
            low_sent <= 1'b0;
            bit_idx  <= '0;
        end else begin
            case (state)
                REP_IDLE:
                    if (pend_cnt != '0) begin
                        rd_req <= 1'b1;
                        state  <= REP_READ;
                    end
                REP_READ:
                    if (rd_done) begin
                        rd_req   <= 1'b0;
                        rd_addr  <= rd_addr + 1'b1;   // Wraps with the writer.
                        low_sent <= 1'b0;
                        state    <= REP_START;
                    end
                REP_START:
                    if (bit_end) begin
                        bit_idx <= '0;
                        state   <= REP_BITS;
                    end
                REP_BITS:
                    if (bit_end) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7)
                            state <= REP_STOP;
                    end
                REP_STOP:
                    if (bit_end)
                        state <= REP_NEXT;
                REP_NEXT:
                    if (!low_sent) begin
                        low_sent <= 1'b1;
                        state    <= REP_START;    // Low byte next.
                    end else begin
                        state <= REP_IDLE;        // Record done.
                    end
                default:
                    state <= REP_IDLE;
            endcase
        end
    end

    // Payload registers.
    always_ff @(posedge clk_133MHz_210) begin
        if (state == REP_READ && rd_done) begin
            rec_data <= rd_data;
            tx_byte  <= rd_data[15:8];    // High byte first.
        end else if (state == REP_NEXT && !low_sent) begin
            tx_byte <= rec_data[7:0];
        end
    end

    //////////////////////////////
    // Line driver.
    //////////////////////////////
    always_comb begin
        case (state)
            REP_START: tx_level = 1'b0;               // Start bit.
            REP_BITS:  tx_level = tx_byte[bit_idx];
            default:   tx_level = 1'b1;               // Idle and stop.
        endcase
    end

    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n)
            uart_txd <= 1'b1;
        else
            uart_txd <= tx_level;   // Registered, glitch free.
    end

    a_idle_line_high: assert property (
        @(posedge clk_133MHz_210) disable iff (!rst_n)
        state == REP_IDLE |-> uart_txd
    );

endmodule

/* rtl/test_signal_gen.sv */
`timescale 1ns/1ps

module test_signal_gen import photon_pkg::*; (
    input  logic clk_133MHz_210,
    input  logic rst_n,
    output logic photon_pulse_simulate,
    output logic sync_50hz_simulate
);

    photon_cnt_t photon_cnt;   // Photon phase.
    sync_cnt_t   sync_cnt;     // Sync phase.

    //////////////////////////////
    // Free-running phases.
    //////////////////////////////
    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            photon_cnt            <= '0;
            sync_cnt              <= '0;
            photon_pulse_simulate <= 1'b0;
            sync_50hz_simulate    <= 1'b0;
        end else begin
            photon_cnt <= (photon_cnt == photon_cnt_t'(SIM_PHOTON_PERIOD - 1)) ?
                          '0 : photon_cnt + 1'b1;
            sync_cnt   <= (sync_cnt == sync_cnt_t'(SIM_SYNC_PERIOD - 1)) ?
                          '0 : sync_cnt + 1'b1;
            // High for the first half of each photon period.
            photon_pulse_simulate <= (photon_cnt < photon_cnt_t'(SIM_PHOTON_PERIOD / 2));
            sync_50hz_simulate    <= (sync_cnt < sync_cnt_t'(SIM_SYNC_HIGH));
        end
    end

endmodule

/* rtl/single_photon_counter.sv */
`timescale 1ns/1ps

module single_photon_counter import photon_pkg::*; (
    input  logic clk_133MHz_210,
    input  logic rst_n,
    input  logic photon_pulse,            // Photon pin.
    input  logic sync_50hz,               // 50 Hz window sync.
    output logic photon_pulse_simulate,   // Loop-back test source.
    output logic sync_50hz_simulate,
    output logic uart_txd,
    output logic led                      // Overrun seen.
);

    //////////////////////////////
    // Interconnect.
    //////////////////////////////
    logic       wr_req;
    record_wr_t wr_record;
    logic       wr_done;
    logic       rd_req;
    buf_addr_t  rd_addr;
    logic       rd_done;
    count_t     rd_data;
    buf_cmd_t   buf_cmd;
    count_t     buf_rdata;

    pulse_counter u_pulse_counter (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .photon_pulse   (photon_pulse),
        .sync_50hz      (sync_50hz),
        .wr_req         (wr_req),
        .wr_record      (wr_record),
        .wr_done        (wr_done),
        .overrun        (led)
    );

    rw_arbiter u_rw_arbiter (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .wr_req         (wr_req),
        .wr_record      (wr_record),
        .wr_done        (wr_done),
        .rd_req         (rd_req),
        .rd_addr        (rd_addr),
        .rd_done        (rd_done),
        .rd_data        (rd_data),
        .buf_cmd        (buf_cmd),
        .buf_rdata      (buf_rdata)
    );

    count_buffer u_count_buffer (
        .clk_133MHz_210 (clk_133MHz_210),
        .buf_cmd        (buf_cmd),
        .buf_rdata      (buf_rdata)
    );

    // Each finished write announces one record.
    count_reporter u_count_reporter (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .record_written (wr_done),
        .rd_req         (rd_req),
        .rd_addr        (rd_addr),
        .rd_done        (rd_done),
        .rd_data        (rd_data),
        .uart_txd       (uart_txd)
    );

    test_signal_gen u_test_signal_gen (
        .clk_133MHz_210        (clk_133MHz_210),
        .rst_n                 (rst_n),
        .photon_pulse_simulate (photon_pulse_simulate),
        .sync_50hz_simulate    (sync_50hz_simulate)
    );

endmodule

/* tests/tb_single_photon_counter.sv */
`timescale 1ns/1ps

module tb_single_photon_counter import photon_pkg::*; ();

    //////////////////////////////
    // Run sizes and budget.
    //////////////////////////////
    localparam int SEED        = 24666;
    localparam int SAT_PHOTONS = 66000;   // Past the count_t maximum.
    localparam int N_DIRECTED  = 3;
    localparam int N_BURST     = 3;
    localparam int N_RECORDS   = N_DIRECTED + 1 + N_BURST + 2 + 3;
    localparam int REC_CYCLES  = 20 * BAUD_DIV + 50;   // Two frames plus handshakes.
    localparam int CYCLE_LIMIT = N_RECORDS * REC_CYCLES + 2 * SAT_PHOTONS + 40000;

    logic   clk_133MHz_210;
    logic   rst_n;
    logic   drv_photon;     // Driven photon pin.
    logic   drv_sync;
    logic   loopback;       // Route simulate outputs to the pins.
    logic   photon_pin;
    logic   sync_pin;
    logic   photon_sim;
    logic   sync_sim;
    logic   uart_txd;
    logic   led;
    count_t rx_q[$];        // Records seen on the UART.
    count_t exp_q[$];       // Records still expected.
    int     value_errs;
    int     other_errs;
    int     cycle_cnt;

    always #4 clk_133MHz_210 = ~clk_133MHz_210;   // 125 MHz stand-in.

    assign photon_pin = loopback ? photon_sim : drv_photon;
    assign sync_pin   = loopback ? sync_sim   : drv_sync;

    single_photon_counter UUT (
        .clk_133MHz_210        (clk_133MHz_210),
        .rst_n                 (rst_n),
        .photon_pulse          (photon_pin),
        .sync_50hz             (sync_pin),
        .photon_pulse_simulate (photon_sim),
        .sync_50hz_simulate    (sync_sim),
        .uart_txd              (uart_txd),
        .led                   (led)
    );

    //////////////////////////////
    // Compare and report.
    //////////////////////////////
    task automatic check_count(input count_t got, input count_t exp, input string what);
        if (got !== exp) begin
            value_errs++;
            $display("Fail %0t ns: %s got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            value_errs++;
            $display("Fail %0t ns: %s got %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic flag_problem(input string msg);
        other_errs++;
        $display("%s at %0t ns", msg, $time);
    endtask

    task automatic print_error_counts();
        $display("Errors: %0d wrong values, %0d other failures", value_errs, other_errs);
    endtask

    //////////////////////////////
    // Pin drivers, all on negedge.
    //////////////////////////////
    task automatic pulse_photons(input int n, input int half);
        repeat (n) begin
            drv_photon = 1'b1;
            repeat (half) @(negedge clk_133MHz_210);
            drv_photon = 1'b0;
            repeat (half) @(negedge clk_133MHz_210);
        end
    endtask

    task automatic pulse_sync();
        drv_sync = 1'b1;
        repeat (4) @(negedge clk_133MHz_210);
        drv_sync = 1'b0;
        repeat (4) @(negedge clk_133MHz_210);
    endtask

    task automatic wait_records(input int n);
        while (rx_q.size() < n)
            @(negedge clk_133MHz_210);    // Watchdog bounds this.
    endtask

    // Pops one received record per expected one, in order.
    task automatic compare_records(input string what);
        count_t got;
        count_t exp;
        wait_records(exp_q.size());
        while (exp_q.size() > 0) begin
            got = rx_q.pop_front();
            exp = exp_q.pop_front();
            check_count(got, exp, what);
        end
    endtask

    task automatic check_line_idle(input int cycles, input string what);
        logic seen_low;
        seen_low = 1'b0;
        repeat (cycles) begin
            @(negedge clk_133MHz_210);
            seen_low |= !uart_txd;
        end
        check_flag(seen_low, 1'b0, what);
    endtask

    //////////////////////////////
    // Directed tests.
    //////////////////////////////
    task automatic watch_idle_line();
        check_line_idle(2 * BAUD_DIV, "uart_txd low before any sync");
        check_flag(led, 1'b0, "led before any sync");
    endtask

    task automatic send_directed_windows();
        int n;
        for (int i = 0; i < N_DIRECTED; i++) begin
            n = $urandom_range(300);
            exp_q.push_back(count_t'(n));
            pulse_photons(n, 4);
            pulse_sync();
        end
        compare_records("directed window");
    endtask

    task automatic saturate_count();
        count_t max_cnt;
        max_cnt = '1;                       // Count holds at all ones.
        pulse_photons(SAT_PHOTONS, 1);
        pulse_sync();
        exp_q.push_back(max_cnt);
        compare_records("saturated window");
    endtask

    // Sync edges 64 cycles apart while the UART is busy.
    task automatic close_windows_back_to_back();
        int n;
        for (int i = 0; i < N_BURST; i++) begin
            n = $urandom_range(5);
            exp_q.push_back(count_t'(n));
            repeat (56 - 8 * n) @(negedge clk_133MHz_210);
            pulse_photons(n, 4);
            pulse_sync();
        end
        compare_records("back to back window");
        check_flag(led, 1'b0, "led after back to back windows");
    endtask

    // Second edge lands as the read holds the buffer, third while write waits.
    task automatic force_overrun();
        logic [7:0] sync_bits;
        int         n;
        sync_bits = 8'b0101_0001;           // LSB first, one bit per cycle.
        check_line_idle(BAUD_DIV, "uart_txd low before overrun pair");
        n = $urandom_range(300, 1);
        exp_q.push_back(count_t'(n));
        exp_q.push_back(count_t'(0));       // Short window, kept.
        pulse_photons(n, 4);
        for (int i = 0; i < 8; i++) begin
            drv_sync = sync_bits[i];
            @(negedge clk_133MHz_210);
        end
        drv_sync = 1'b0;
        compare_records("overrun pair");
        check_flag(led, 1'b1, "led after overrun");
        check_line_idle(2 * BAUD_DIV, "extra record after overrun pair");
    endtask

    task automatic run_loopback();
        count_t rate;
        count_t got;
        rate = count_t'(SIM_SYNC_PERIOD / SIM_PHOTON_PERIOD);
        // Switch while both sources are low, so no false edge.
        do
            @(negedge clk_133MHz_210);
        while (photon_sim || sync_sim);
        loopback = 1'b1;
        wait_records(3);
        got = rx_q.pop_front();             // Partial first window.
        for (int i = 0; i < 2; i++) begin
            got = rx_q.pop_front();
            check_count(got, rate, "loop-back window");
        end
        check_flag(led, 1'b1, "led held after loop-back");
    endtask

    //////////////////////////////
    // UART receiver.
    //////////////////////////////
    initial begin : uart_monitor
        uart_byte_t rx_byte;
        uart_byte_t high_byte;
        logic       have_high;
        have_high = 1'b0;
        @(posedge rst_n);
        forever begin
            @(negedge clk_133MHz_210);
            if (uart_txd === 1'b0) begin
                repeat (BAUD_DIV / 2) @(negedge clk_133MHz_210);  // Mid start bit.
                if (uart_txd !== 1'b0)
                    flag_problem("UART start bit did not hold to mid-bit");
                for (int b = 0; b < 8; b++) begin
                    repeat (BAUD_DIV) @(negedge clk_133MHz_210);
                    rx_byte[b] = uart_txd;
                end
                repeat (BAUD_DIV) @(negedge clk_133MHz_210);
                if (uart_txd !== 1'b1)
                    flag_problem("UART stop bit missing");
                if (have_high) begin
                    rx_q.push_back({high_byte, rx_byte});
                    have_high = 1'b0;
                end else begin
                    high_byte = rx_byte;    // High byte comes first.
                    have_high = 1'b1;
                end
            end
        end
    end

    initial begin : watchdog
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk_133MHz_210);
            cycle_cnt++;
        end
        $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        print_error_counts();
        $display("Simulation FAILED");
        $finish;
    end

    //////////////////////////////
    // Main sequence.
    //////////////////////////////
    initial begin
        void'($urandom(SEED));
        clk_133MHz_210 = 1'b0;
        rst_n          = 1'b0;
        drv_photon     = 1'b0;
        drv_sync       = 1'b0;
        loopback       = 1'b0;
        value_errs     = 0;
        other_errs     = 0;
        repeat (5) @(posedge clk_133MHz_210);
        @(negedge clk_133MHz_210);
        rst_n = 1'b1;

        watch_idle_line();
        send_directed_windows();
        saturate_count();
        close_windows_back_to_back();
        force_overrun();
        run_loopback();

        print_error_counts();
        if (value_errs == 0 && other_errs == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* src.f */
rtl/photon_pkg.sv
rtl/pulse_counter.sv
rtl/rw_arbiter.sv
rtl/count_buffer.sv
rtl/count_reporter.sv
rtl/test_signal_gen.sv
rtl/single_photon_counter.sv
tests/tb_single_photon_counter.sv

/* Makefile */
# Verilator build and run for the photon counter.
TOP := tb_single_photon_counter

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -j 0 -f src.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation PASSED" sim.log

lint:
	verilator --lint-only --timing -f src.f --top-module single_photon_counter

clean:
	rm -rf obj_dir sim.log
